/* verilog/lane_pkg.sv */
package lane_pkg;

  // Defaults that the top level hands down
  localparam int DATA_WIDTH_DEF = 32;
  localparam int REG_NUM_DEF    = 8;
  localparam int ELEMS_DEF      = 8;
  localparam int ALU_LAT_DEF    = 3;

  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    MIN = 3'd5,
    MAX = 3'd6,
    MUL = 3'd7
  } alu_op_e;

  // Source of operand A
  typedef enum logic [1:0] {
    VV = 2'd0,
    VX = 2'd1,
    VI = 2'd2
  } operand_sel_e;

  typedef enum logic [2:0] {
    IDLE,
    READ_B,
    READ_A,
    READ_MASK,
    ISSUE
  } fetch_state_e;

  // vd and vs2 keep the low 3 bits of a 5-bit register slot
  typedef struct packed {
    alu_op_e      op;
    operand_sel_e sel;
    logic         vm;
    logic [2:0]   vd;
    logic [4:0]   vs1_imm;
    logic [2:0]   vs2;
  } lane_instr_t;

endpackage

/* verilog/vrf_port_if.sv */
interface vrf_port_if #(
  parameter int DATA_WIDTH = 32,
  parameter int REG_NUM    = 8,
  parameter int ELEMS      = 8
) ();

  logic                       req;
  logic                       we;
  logic [$clog2(REG_NUM)-1:0] reg_idx;
  logic [$clog2(ELEMS)-1:0]   elem;
  logic [DATA_WIDTH-1:0]      wdata;
  logic                       gnt;
  // Valid in the grant cycle
  logic [DATA_WIDTH-1:0]      rdata;

  modport requester (
    output req, we, reg_idx, elem, wdata,
    input  gnt, rdata
  );

  modport arbiter (
    input  req, we, reg_idx, elem, wdata,
    output gnt, rdata
  );

endinterface

/* verilog/vrf_arbiter.sv */
module vrf_arbiter #(
  parameter int DATA_WIDTH = 32,
  parameter int REG_NUM    = 8,
  parameter int ELEMS      = 8,
  localparam int REG_B     = $clog2(REG_NUM),
  localparam int ELEM_B    = $clog2(ELEMS),
  localparam int CNT_B     = $clog2(ELEMS + 1)
) (
  input  logic                  clk_i,
  input  logic                  resetn_i,
  vrf_port_if.arbiter           host_port,
  vrf_port_if.arbiter           fetch_port,
  vrf_port_if.arbiter           wb_port,
  output logic                  we_o,
  output logic [REG_B-1:0]      reg_idx_o,
  output logic [ELEM_B-1:0]     elem_o,
  output logic [DATA_WIDTH-1:0] wdata_o,
  input  logic [DATA_WIDTH-1:0] rdata_i
);

  logic [CNT_B-1:0] deny_cnt_q;
  logic             host_first;

  // Host jumps ahead of fetch once it has waited long enough
  assign host_first = host_port.req && (deny_cnt_q == CNT_B'(ELEMS));

  always_comb begin
    wb_port.gnt    = wb_port.req;
    fetch_port.gnt = fetch_port.req && !wb_port.req && !host_first;
    host_port.gnt  = host_port.req && !wb_port.req && (!fetch_port.req || host_first);

    if (wb_port.gnt) begin
      we_o      = wb_port.we;
      reg_idx_o = wb_port.reg_idx;
      elem_o    = wb_port.elem;
      wdata_o   = wb_port.wdata;
    end else if (fetch_port.gnt) begin
      we_o      = fetch_port.we;
      reg_idx_o = fetch_port.reg_idx;
      elem_o    = fetch_port.elem;
      wdata_o   = fetch_port.wdata;
    end else begin
      we_o      = host_port.gnt && host_port.we;
      reg_idx_o = host_port.reg_idx;
      elem_o    = host_port.elem;
      wdata_o   = host_port.wdata;
    end
  end

  assign host_port.rdata  = rdata_i;
  assign fetch_port.rdata = rdata_i;
  assign wb_port.rdata    = rdata_i;

  // Consecutive host denials, saturating
  always_ff @(posedge clk_i or negedge resetn_i) begin
    if (!resetn_i) begin
      deny_cnt_q <= '0;
    end else if (!host_port.req || host_port.gnt) begin
      deny_cnt_q <= '0;
    end else if (deny_cnt_q != CNT_B'(ELEMS)) begin
      deny_cnt_q <= deny_cnt_q + 1'b1;
    end
  end

endmodule

/* verilog/vector_regfile.sv */
module vector_regfile #(
  parameter int DATA_WIDTH = 32,
  parameter int REG_NUM    = 8,
  parameter int ELEMS      = 8,
  localparam int REG_B     = $clog2(REG_NUM),
  localparam int ELEM_B    = $clog2(ELEMS)
) (
  input  logic                  clk_i,
  input  logic                  resetn_i,
  input  logic                  we_i,
  input  logic [REG_B-1:0]      reg_idx_i,
  input  logic [ELEM_B-1:0]     elem_i,
  input  logic [DATA_WIDTH-1:0] wdata_i,
  output logic [DATA_WIDTH-1:0] rdata_o
);

  logic [DATA_WIDTH-1:0] mem_q [REG_NUM][ELEMS];

  always_ff @(posedge clk_i or negedge resetn_i) begin
    if (!resetn_i) begin
      for (int r = 0; r < REG_NUM; r++) begin
        for (int e = 0; e < ELEMS; e++) begin
          mem_q[r][e] <= '0;
        end
      end
    end else if (we_i) begin
      mem_q[reg_idx_i][elem_i] <= wdata_i;
    end
  end

  // Combinational read, seen by the requester in its grant cycle
  assign rdata_o = mem_q[reg_idx_i][elem_i];

endmodule

/* verilog/apb_lane_regs.sv */
module apb_lane_regs import lane_pkg::*; #(
  parameter int DATA_WIDTH = 32,
  parameter int REG_NUM    = 8,
  parameter int ELEMS      = 8,
  localparam int REG_B     = $clog2(REG_NUM),
  localparam int ELEM_B    = $clog2(ELEMS)
) (
  input  logic                  clk_i,
  input  logic                  resetn_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [7:0]            paddr_i,
  input  logic [DATA_WIDTH-1:0] pwdata_i,
  output logic [DATA_WIDTH-1:0] prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  vrf_port_if.requester         host_port,
  input  logic                  done_i,
  output lane_instr_t           instr_o,
  output logic [DATA_WIDTH-1:0] scalar_o,
  output logic                  start_o
);

  localparam logic [7:0] ADDR_SCALAR = 8'h40;
  localparam logic [7:0] ADDR_INSTR  = 8'h44;
  localparam logic [7:0] ADDR_STATUS = 8'h48;

  logic        access;
  logic        is_elem;
  logic        busy_q;
  lane_instr_t instr_q;
  logic [DATA_WIDTH-1:0] scalar_q;

  assign access  = psel_i && penable_i;
  assign is_elem = (paddr_i < 8'(REG_NUM * ELEMS));

  // Element accesses go to the register file port
  assign host_port.req     = access && is_elem;
  assign host_port.we      = pwrite_i;
  assign host_port.reg_idx = paddr_i[ELEM_B +: REG_B];
  assign host_port.elem    = paddr_i[ELEM_B-1:0];
  assign host_port.wdata   = pwdata_i;

  // An instruction write waits while the previous one runs
  assign start_o = access && pwrite_i && (paddr_i == ADDR_INSTR) && !busy_q;

  always_comb begin
    if (is_elem) begin
      pready_o = access && host_port.gnt;
    end else if (pwrite_i && (paddr_i == ADDR_INSTR)) begin
      pready_o = access && !busy_q;
    end else begin
      pready_o = access;
    end
  end

  always_comb begin
    if (is_elem) begin
      prdata_o = host_port.rdata;
    end else begin
      case (paddr_i)
        ADDR_SCALAR: prdata_o = scalar_q;
        ADDR_INSTR:  prdata_o = DATA_WIDTH'(instr_q);
        ADDR_STATUS: prdata_o = DATA_WIDTH'(busy_q);
        default:     prdata_o = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge resetn_i) begin
    if (!resetn_i) begin
      scalar_q <= '0;
      instr_q  <= '0;
      busy_q   <= 1'b0;
    end else begin
      if (access && pwrite_i && (paddr_i == ADDR_SCALAR)) begin
        scalar_q <= pwdata_i;
      end
      if (start_o) begin
        instr_q <= lane_instr_t'(pwdata_i[$bits(lane_instr_t)-1:0]);
        busy_q  <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign instr_o   = instr_q;
  assign scalar_o  = scalar_q;
  assign pslverr_o = 1'b0;

endmodule

/* verilog/operand_fetch.sv */
module operand_fetch import lane_pkg::*; #(
  parameter int DATA_WIDTH = 32,
  parameter int REG_NUM    = 8,
  parameter int ELEMS      = 8,
  localparam int REG_B     = $clog2(REG_NUM),
  localparam int ELEM_B    = $clog2(ELEMS)
) (
  input  logic                  clk_i,
  input  logic                  resetn_i,
  input  logic                  start_i,
  input  lane_instr_t           instr_i,
  input  logic [DATA_WIDTH-1:0] scalar_i,
  vrf_port_if.requester         fetch_port,
  output logic                  valid_o,
  output logic [DATA_WIDTH-1:0] a_o,
  output logic [DATA_WIDTH-1:0] b_o,
  output alu_op_e               op_o,
  output logic [ELEM_B-1:0]     elem_o,
  output logic                  wr_en_o,
  output logic                  last_o
);

  fetch_state_e          state_q, state_d;
  logic [ELEM_B-1:0]     cnt_q;
  logic [DATA_WIDTH-1:0] a_q, b_q, scalar_q;
  logic                  mask_q;
  logic                  last_elem;

  assign last_elem = (cnt_q == ELEM_B'(ELEMS - 1));

  //////////////////////////////////////////////////
  // Element sequencer
  //////////////////////////////////////////////////

  // READ_A only for VV, READ_MASK only when masked
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (start_i) state_d = READ_B;
      READ_B:    if (fetch_port.gnt) begin
        if (instr_i.sel == VV) state_d = READ_A;
        else                   state_d = instr_i.vm ? ISSUE : READ_MASK;
      end
      READ_A:    if (fetch_port.gnt) state_d = instr_i.vm ? ISSUE : READ_MASK;
      READ_MASK: if (fetch_port.gnt) state_d = ISSUE;
      ISSUE:     state_d = last_elem ? IDLE : READ_B;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge resetn_i) begin
    if (!resetn_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE) cnt_q <= '0;
      else if (state_q == ISSUE && !last_elem) cnt_q <= cnt_q + 1'b1;
    end
  end

  // Operand capture in the grant cycle
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && start_i) scalar_q <= scalar_i;
    if (state_q == READ_B && fetch_port.gnt) b_q <= fetch_port.rdata;
    if (state_q == READ_A && fetch_port.gnt) a_q <= fetch_port.rdata;
    if (state_q == READ_MASK && fetch_port.gnt) mask_q <= fetch_port.rdata[0];
  end

  always_comb begin
    fetch_port.req     = (state_q == READ_B) || (state_q == READ_A) || (state_q == READ_MASK);
    fetch_port.reg_idx = REG_B'(instr_i.vs2);
    if (state_q == READ_A) fetch_port.reg_idx = REG_B'(instr_i.vs1_imm);
    if (state_q == READ_MASK) fetch_port.reg_idx = '0;
  end

  assign fetch_port.we    = 1'b0;
  assign fetch_port.elem  = cnt_q;
  assign fetch_port.wdata = '0;

  //////////////////////////////////////////////////
  // Issue to the ALU
  //////////////////////////////////////////////////

  always_comb begin
    case (instr_i.sel)
      VX:      a_o = scalar_q;
      VI:      a_o = DATA_WIDTH'(instr_i.vs1_imm);
      default: a_o = a_q;
    endcase
  end

  assign valid_o = (state_q == ISSUE);
  assign b_o     = b_q;
  assign op_o    = instr_i.op;
  assign elem_o  = cnt_q;
  assign wr_en_o = instr_i.vm || mask_q;
  assign last_o  = valid_o && last_elem;

endmodule

/* verilog/vector_alu.sv */
module vector_alu import lane_pkg::*; #(
  parameter int DATA_WIDTH = 32,
  parameter int ELEMS      = 8,
  parameter int ALU_LAT    = 3,
  localparam int ELEM_B    = $clog2(ELEMS)
) (
  input  logic                  clk_i,
  input  logic                  resetn_i,
  input  logic                  valid_i,
  input  logic [DATA_WIDTH-1:0] a_i,
  input  logic [DATA_WIDTH-1:0] b_i,
  input  alu_op_e               op_i,
  input  logic [ELEM_B-1:0]     elem_i,
  input  logic                  wr_en_i,
  input  logic                  last_i,
  output logic                  valid_o,
  output logic [DATA_WIDTH-1:0] result_o,
  output logic [ELEM_B-1:0]     elem_o,
  output logic                  wr_en_o,
  output logic                  last_o
);

  logic [DATA_WIDTH-1:0] result_d;
  logic                  b_lt_a;
  logic [ALU_LAT-1:0]    valid_q;
  logic [ALU_LAT-1:0]    wr_en_q;
  logic [ALU_LAT-1:0]    last_q;
  logic [DATA_WIDTH-1:0] result_q [ALU_LAT];
  logic [ELEM_B-1:0]     elem_q [ALU_LAT];

  assign b_lt_a = ($signed(b_i) < $signed(a_i));

  // vd = vs2 op A
  always_comb begin
    case (op_i)
      ADD:     result_d = b_i + a_i;
      SUB:     result_d = b_i - a_i;
      AND:     result_d = b_i & a_i;
      OR:      result_d = b_i | a_i;
      XOR:     result_d = b_i ^ a_i;
      MIN:     result_d = b_lt_a ? b_i : a_i;
      MAX:     result_d = b_lt_a ? a_i : b_i;
      MUL:     result_d = b_i * a_i;
      default: result_d = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Delay line, one element per stage
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge resetn_i) begin
    if (!resetn_i) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= valid_i;
      for (int i = 1; i < ALU_LAT; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    result_q[0] <= result_d;
    elem_q[0]   <= elem_i;
    wr_en_q[0]  <= wr_en_i;
    last_q[0]   <= last_i;
    for (int i = 1; i < ALU_LAT; i++) begin
      result_q[i] <= result_q[i-1];
      elem_q[i]   <= elem_q[i-1];
      wr_en_q[i]  <= wr_en_q[i-1];
      last_q[i]   <= last_q[i-1];
    end
  end

  assign valid_o  = valid_q[ALU_LAT-1];
  assign result_o = result_q[ALU_LAT-1];
  assign elem_o   = elem_q[ALU_LAT-1];
  assign wr_en_o  = wr_en_q[ALU_LAT-1];
  assign last_o   = last_q[ALU_LAT-1];

endmodule

/* verilog/lane_writeback.sv */
module lane_writeback #(
  parameter int DATA_WIDTH = 32,
  parameter int REG_NUM    = 8,
  parameter int ELEMS      = 8,
  localparam int REG_B     = $clog2(REG_NUM),
  localparam int ELEM_B    = $clog2(ELEMS)
) (
  input  logic                  clk_i,
  input  logic                  resetn_i,
  input  logic                  valid_i,
  input  logic [DATA_WIDTH-1:0] result_i,
  input  logic [ELEM_B-1:0]     elem_i,
  input  logic                  wr_en_i,
  input  logic                  last_i,
  input  logic [REG_B-1:0]      vd_i,
  vrf_port_if.requester         wb_port,
  output logic                  done_o
);

  logic                  buf_valid_q;
  logic [DATA_WIDTH-1:0] buf_data_q;
  logic [ELEM_B-1:0]     buf_elem_q;
  logic                  buf_last_q;
  logic                  load;

  // Masked-off results never enter the buffer
  assign load = valid_i && wr_en_i;

  always_ff @(posedge clk_i or negedge resetn_i) begin
    if (!resetn_i) begin
      buf_valid_q <= 1'b0;
    end else begin
      buf_valid_q <= load || (buf_valid_q && !wb_port.gnt);
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      buf_data_q <= result_i;
      buf_elem_q <= elem_i;
      buf_last_q <= last_i;
    end
  end

  assign wb_port.req     = buf_valid_q;
  assign wb_port.we      = 1'b1;
  assign wb_port.reg_idx = vd_i;
  assign wb_port.elem    = buf_elem_q;
  assign wb_port.wdata   = buf_data_q;

  // Last element retires on its write, or at once if skipped
  assign done_o = (buf_valid_q && wb_port.gnt && buf_last_q) || (valid_i && last_i && !wr_en_i);

endmodule

/* verilog/vector_lane.sv */
module vector_lane import lane_pkg::*; #(
  parameter int DATA_WIDTH = DATA_WIDTH_DEF,
  parameter int REG_NUM    = REG_NUM_DEF,
  parameter int ELEMS      = ELEMS_DEF,
  parameter int ALU_LAT    = ALU_LAT_DEF,
  localparam int REG_B     = $clog2(REG_NUM),
  localparam int ELEM_B    = $clog2(ELEMS)
) (
  input  logic                  clk_i,
  input  logic                  resetn_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [7:0]            paddr_i,
  input  logic [DATA_WIDTH-1:0] pwdata_i,
  output logic [DATA_WIDTH-1:0] prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o
);

  lane_instr_t           instr;
  logic [DATA_WIDTH-1:0] scalar;
  logic                  start, done;
  logic                  rf_we;
  logic [REG_B-1:0]      rf_reg_idx;
  logic [ELEM_B-1:0]     rf_elem;
  logic [DATA_WIDTH-1:0] rf_wdata, rf_rdata;
  // Fetch to ALU
  logic                  ex_valid, ex_wr_en, ex_last;
  logic [DATA_WIDTH-1:0] ex_a, ex_b;
  alu_op_e               ex_op;
  logic [ELEM_B-1:0]     ex_elem;
  // ALU to writeback
  logic                  res_valid, res_wr_en, res_last;
  logic [DATA_WIDTH-1:0] res_data;
  logic [ELEM_B-1:0]     res_elem;

  vrf_port_if #(.DATA_WIDTH(DATA_WIDTH), .REG_NUM(REG_NUM), .ELEMS(ELEMS)) host_port ();
  vrf_port_if #(.DATA_WIDTH(DATA_WIDTH), .REG_NUM(REG_NUM), .ELEMS(ELEMS)) fetch_port ();
  vrf_port_if #(.DATA_WIDTH(DATA_WIDTH), .REG_NUM(REG_NUM), .ELEMS(ELEMS)) wb_port ();

  vrf_arbiter #(.DATA_WIDTH(DATA_WIDTH), .REG_NUM(REG_NUM), .ELEMS(ELEMS)) u_arbiter (
    .clk_i, .resetn_i, .host_port, .fetch_port, .wb_port,
    .we_o(rf_we), .reg_idx_o(rf_reg_idx), .elem_o(rf_elem),
    .wdata_o(rf_wdata), .rdata_i(rf_rdata)
  );

  vector_regfile #(.DATA_WIDTH(DATA_WIDTH), .REG_NUM(REG_NUM), .ELEMS(ELEMS)) u_regfile (
    .clk_i, .resetn_i, .we_i(rf_we), .reg_idx_i(rf_reg_idx), .elem_i(rf_elem),
    .wdata_i(rf_wdata), .rdata_o(rf_rdata)
  );

  apb_lane_regs #(.DATA_WIDTH(DATA_WIDTH), .REG_NUM(REG_NUM), .ELEMS(ELEMS)) u_regs (
    .clk_i, .resetn_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o, .host_port, .done_i(done),
    .instr_o(instr), .scalar_o(scalar), .start_o(start)
  );

  operand_fetch #(.DATA_WIDTH(DATA_WIDTH), .REG_NUM(REG_NUM), .ELEMS(ELEMS)) u_fetch (
    .clk_i, .resetn_i, .start_i(start), .instr_i(instr), .scalar_i(scalar), .fetch_port,
    .valid_o(ex_valid), .a_o(ex_a), .b_o(ex_b), .op_o(ex_op), .elem_o(ex_elem),
    .wr_en_o(ex_wr_en), .last_o(ex_last)
  );

  vector_alu #(.DATA_WIDTH(DATA_WIDTH), .ELEMS(ELEMS), .ALU_LAT(ALU_LAT)) u_alu (
    .clk_i, .resetn_i, .valid_i(ex_valid), .a_i(ex_a), .b_i(ex_b), .op_i(ex_op),
    .elem_i(ex_elem), .wr_en_i(ex_wr_en), .last_i(ex_last), .valid_o(res_valid),
    .result_o(res_data), .elem_o(res_elem), .wr_en_o(res_wr_en), .last_o(res_last)
  );

  lane_writeback #(.DATA_WIDTH(DATA_WIDTH), .REG_NUM(REG_NUM), .ELEMS(ELEMS)) u_wb (
    .clk_i, .resetn_i, .valid_i(res_valid), .result_i(res_data), .elem_i(res_elem),
    .wr_en_i(res_wr_en), .last_i(res_last), .vd_i(REG_B'(instr.vd)), .wb_port,
    .done_o(done)
  );

endmodule

/* include/lane_model.svh */
`ifndef LANE_MODEL_SVH
`define LANE_MODEL_SVH

// Mirror of the lane registers, one instruction at a time
logic [DATA_WIDTH_DEF-1:0] ref_regs [REG_NUM_DEF][ELEMS_DEF];
logic [DATA_WIDTH_DEF-1:0] ref_scalar;

function automatic void clear_model();
  for (int r = 0; r < REG_NUM_DEF; r++) begin
    for (int e = 0; e < ELEMS_DEF; e++) begin
      ref_regs[r][e] = '0;
    end
  end
  ref_scalar = '0;
endfunction

// Element address as seen on APB
function automatic void store_element(input logic [7:0] addr,
                                      input logic [DATA_WIDTH_DEF-1:0] data);
  ref_regs[addr / ELEMS_DEF][addr % ELEMS_DEF] = data;
endfunction

// Result of vs2 op A for one element
function automatic logic [DATA_WIDTH_DEF-1:0] apply_op(input alu_op_e op,
                                                       input logic [DATA_WIDTH_DEF-1:0] a,
                                                       input logic [DATA_WIDTH_DEF-1:0] b);
  logic signed [DATA_WIDTH_DEF-1:0] sa;
  logic signed [DATA_WIDTH_DEF-1:0] sb;
  logic [2*DATA_WIDTH_DEF-1:0]      prod;
  logic [DATA_WIDTH_DEF-1:0]        res;
  sa   = a;
  sb   = b;
  prod = {{DATA_WIDTH_DEF{1'b0}}, b} * {{DATA_WIDTH_DEF{1'b0}}, a};
  case (op)
    ADD:     res = b + a;
    SUB:     res = b - a;
    AND:     res = b & a;
    OR:      res = b | a;
    XOR:     res = b ^ a;
    MIN:     res = (sa < sb) ? a : b;
    MAX:     res = (sa > sb) ? a : b;
    MUL:     res = prod[DATA_WIDTH_DEF-1:0];
    default: res = '0;
  endcase
  return res;
endfunction

// Element by element, as the lane retires them
function automatic void execute_instr(input lane_instr_t instr);
  logic [DATA_WIDTH_DEF-1:0] a;
  logic [DATA_WIDTH_DEF-1:0] b;
  logic                      en;
  for (int e = 0; e < ELEMS_DEF; e++) begin
    b = ref_regs[instr.vs2][e];
    case (instr.sel)
      VX:      a = ref_scalar;
      VI:      a = {{(DATA_WIDTH_DEF-5){1'b0}}, instr.vs1_imm};
      default: a = ref_regs[instr.vs1_imm[2:0]][e];
    endcase
    en = instr.vm || ref_regs[0][e][0];
    if (en) begin
      ref_regs[instr.vd][e] = apply_op(instr.op, a, b);
    end
  end
endfunction

`endif

/* testbench/tb_vector_lane.sv */
module tb_vector_lane import lane_pkg::*; ();

  `include "lane_model.svh"

  localparam int DW          = DATA_WIDTH_DEF;
  localparam int N_ELEM_ADDR = REG_NUM_DEF * ELEMS_DEF;
  localparam logic [7:0] ADDR_SCALAR = 8'h40;
  localparam logic [7:0] ADDR_INSTR  = 8'h44;
  localparam logic [7:0] ADDR_STATUS = 8'h48;

  // Run length: reset, three full passes over the elements, then the instructions
  localparam int ACCESS_CYC = 3;
  localparam int INSTR_CYC  = 48;
  localparam int N_INSTR    = 34;
  localparam int LIMIT      = 16 + ACCESS_CYC * 3 * N_ELEM_ADDR
                              + N_INSTR * (INSTR_CYC + ACCESS_CYC * (ELEMS_DEF + 4));

  logic          clk_i;
  logic          resetn_i;
  logic          psel_i;
  logic          penable_i;
  logic          pwrite_i;
  logic [7:0]    paddr_i;
  logic [DW-1:0] pwdata_i;
  logic [DW-1:0] prdata_o;
  logic          pready_o;
  logic          pslverr_o;

  integer    seed;
  int        errors;
  int        checks;
  int        cycles;

  vector_lane UUT (
    .clk_i, .resetn_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o
  );

  always #50 clk_i = ~clk_i;

  task automatic compare_value(input string name, input logic [DW-1:0] got,
                               input logic [DW-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // APB access
  //////////////////////////////////////////////////

  task automatic bus_access(input logic wr, input logic [7:0] addr,
                            input logic [DW-1:0] wdata, output logic [DW-1:0] rdata);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge clk_i);
    penable_i <= 1'b1;
    // pready_o settles from registered state by the falling edge
    @(negedge clk_i);
    while (!pready_o) @(negedge clk_i);
    rdata = prdata_o;
    compare_value("pslverr_o", DW'(pslverr_o), '0);
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic write_word(input logic [7:0] addr, input logic [DW-1:0] data);
    logic [DW-1:0] unused;
    bus_access(1'b1, addr, data, unused);
  endtask

  task automatic read_word(input logic [7:0] addr, output logic [DW-1:0] data);
    bus_access(1'b0, addr, '0, data);
  endtask

  task automatic set_scalar(input logic [DW-1:0] value);
    write_word(ADDR_SCALAR, value);
    ref_scalar = value;
  endtask

  task automatic wait_idle();
    logic [DW-1:0] status;
    status = '1;
    while (status[0]) read_word(ADDR_STATUS, status);
  endtask

  task automatic check_register(input int r);
    logic [DW-1:0] data;
    for (int e = 0; e < ELEMS_DEF; e++) begin
      read_word(8'(r * ELEMS_DEF + e), data);
      compare_value($sformatf("v%0d[%0d]", r, e), data, ref_regs[r][e]);
    end
  endtask

  function automatic lane_instr_t random_instr(input alu_op_e op, input operand_sel_e sel,
                                               input logic vm);
    lane_instr_t   instr;
    logic [31:0]   r;
    r             = $random(seed);
    instr.op      = op;
    instr.sel     = sel;
    instr.vm      = vm;
    instr.vd      = r[2:0];
    instr.vs1_imm = r[8:4];
    instr.vs2     = r[14:12];
    return instr;
  endfunction

  task automatic run_instr(input lane_instr_t instr);
    write_word(ADDR_INSTR, DW'(instr));
    execute_instr(instr);
    wait_idle();
    check_register(int'(instr.vd));
  endtask

  // Cycle limit for the whole run
  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("ERROR: timeout, the run did not finish within %0d cycles", LIMIT);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    logic [DW-1:0] data;
    lane_instr_t   first;
    lane_instr_t   second;
    clk_i     = 1'b0;
    resetn_i  = 1'b0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    errors    = 0;
    checks    = 0;
    seed      = 32'h8fa2_2ace;
    clear_model();

    repeat (16) @(posedge clk_i);
    resetn_i <= 1'b1;
    @(negedge clk_i);
    compare_value("pready_o", DW'(pready_o), '0);

    //////////////////////////////////////////////////
    // Load and readback
    //////////////////////////////////////////////////
    for (int a = 0; a < N_ELEM_ADDR; a++) begin
      data = $random(seed);
      write_word(8'(a), data);
      store_element(8'(a), data);
    end
    for (int r = 0; r < REG_NUM_DEF; r++) begin
      check_register(r);
    end

    // Every opcode, vector-vector
    for (int k = 0; k < 8; k++) begin
      run_instr(random_instr(alu_op_e'(k), VV, 1'b1));
    end

    // Scalar and immediate operand A
    for (int k = 0; k < 8; k++) begin
      set_scalar($random(seed));
      run_instr(random_instr(alu_op_e'(k), VX, 1'b1));
    end
    for (int k = 0; k < 8; k++) begin
      run_instr(random_instr(alu_op_e'(k), VI, 1'b1));
    end

    //////////////////////////////////////////////////
    // Masking from v0
    //////////////////////////////////////////////////
    for (int e = 0; e < ELEMS_DEF; e++) begin
      data = $random(seed);
      write_word(8'(e), data);
      store_element(8'(e), data);
    end
    for (int k = 0; k < 8; k++) begin
      run_instr(random_instr(alu_op_e'(k), operand_sel_e'(k % 3), 1'b0));
    end

    //////////////////////////////////////////////////
    // Busy and back-pressure
    //////////////////////////////////////////////////
    first = random_instr(ADD, VV, 1'b0);
    write_word(ADDR_INSTR, DW'(first));
    execute_instr(first);
    read_word(ADDR_STATUS, data);
    compare_value("status busy", DW'(data[0]), DW'(1));
    // Register untouched by the running instruction
    read_word(8'(((int'(first.vd) + 1) % REG_NUM_DEF) * ELEMS_DEF + 3), data);
    compare_value("element read while busy", data,
                  ref_regs[(int'(first.vd) + 1) % REG_NUM_DEF][3]);
    // Held off by pready_o until the first instruction is done
    second = random_instr(MUL, VX, 1'b1);
    write_word(ADDR_INSTR, DW'(second));
    execute_instr(second);
    wait_idle();
    read_word(ADDR_STATUS, data);
    compare_value("status idle", data, '0);
    check_register(int'(first.vd));
    check_register(int'(second.vd));

    // Nothing outside the destinations changed
    for (int r = 0; r < REG_NUM_DEF; r++) begin
      check_register(r);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+include
verilog/lane_pkg.sv
verilog/vrf_port_if.sv
verilog/vrf_arbiter.sv
verilog/vector_regfile.sv
verilog/apb_lane_regs.sv
verilog/operand_fetch.sv
verilog/vector_alu.sv
verilog/lane_writeback.sv
verilog/vector_lane.sv
testbench/tb_vector_lane.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_vector_lane \
  -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi
echo "Simulation finished without failures"
